/* logic/ex_pkg.sv */
// shared types for the execute stage
// instruction formats, unit selects and the packets that pass through
// reference as ex_pkg::name from every user

package ex_pkg;

	parameter int xlen = 32;

	localparam logic [6:0] opcode_jalr = 7'b1100111;

	////////////////////
	// instruction word
	////////////////////

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_t;

	////////////////////
	// selects
	////////////////////

	typedef enum logic [1:0] {
		opa_is_rs1,
		opa_is_npc,
		opa_is_pc,
		opa_is_zero
	} opa_sel_e;

	typedef enum logic [2:0] {
		opb_is_rs2,
		opb_is_i_imm,
		opb_is_s_imm,
		opb_is_b_imm,
		opb_is_u_imm,
		opb_is_j_imm
	} opb_sel_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_slt,
		alu_sltu,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_mul,
		alu_mulh,
		alu_mulhsu,
		alu_mulhu
	} alu_func_e;

	// which unit takes the issue packet
	typedef enum logic [1:0] {
		ch_none,
		ch_alu,
		ch_br,
		ch_mult
	} channel_e;

	////////////////////
	// packets
	////////////////////

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;
		inst_t           inst;
		logic [xlen-1:0] rs1_value;
		logic [xlen-1:0] rs2_value;
		opa_sel_e        opa_select;
		opb_sel_e        opb_select;
		alu_func_e       alu_func;
		channel_e        channel;
		logic            cond_branch;
		logic            uncond_branch;
		logic [4:0]      dest_reg_idx;
		logic            rd_mem;
		logic            wr_mem;
		logic            halt;
	} is_packet_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;
		logic [xlen-1:0] alu_result;
		logic            take_branch;
		logic [xlen-1:0] rs2_value;
		logic [4:0]      dest_reg_idx;
		logic            rd_mem;
		logic            wr_mem;
		logic [2:0]      mem_size;
		logic            halt;
	} ex_packet_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] target_pc;
		logic            taken;
		logic            valid;
	} ex2btb_packet_t;

	////////////////////
	// immediates
	////////////////////

	function automatic logic [xlen-1:0] i_imm(input inst_t inst);
		return {{20{inst.i.imm[11]}}, inst.i.imm};
	endfunction

	function automatic logic [xlen-1:0] s_imm(input inst_t inst);
		return {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
	endfunction

	function automatic logic [xlen-1:0] b_imm(input inst_t inst);
		return {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
			inst.b.imm4_1, 1'b0};
	endfunction

	// upper 20 bits, low 12 cleared
	function automatic logic [xlen-1:0] u_imm(input inst_t inst);
		return {inst.u.imm, 12'b0};
	endfunction

	function automatic logic [xlen-1:0] j_imm(input inst_t inst);
		return {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
			inst.j.imm10_1, 1'b0};
	endfunction

endpackage

/* logic/ex_alu.sv */
// integer ALU of the execute stage
// purely combinational, done follows start in the same cycle

`timescale 1ns/1ns

module ex_alu (
	input  logic [ex_pkg::xlen-1:0] opa,
	input  logic [ex_pkg::xlen-1:0] opb,
	input  ex_pkg::alu_func_e       func,
	input  logic                    start,
	input  ex_pkg::is_packet_t      packet_in,
	output logic [ex_pkg::xlen-1:0] result,
	output logic                    done,
	output ex_pkg::is_packet_t      packet_out
);

	logic signed [ex_pkg::xlen-1:0] sa;
	logic signed [ex_pkg::xlen-1:0] sb;
	logic [4:0] shamt;

	assign sa = opa;
	assign sb = opb;
	// only the low five bits shift on rv32
	assign shamt = opb[4:0];

	always_comb begin
		case (func)
			ex_pkg::alu_add:  result = opa + opb;
			ex_pkg::alu_sub:  result = opa - opb;
			ex_pkg::alu_slt:  result = {31'b0, sa < sb};
			ex_pkg::alu_sltu: result = {31'b0, opa < opb};
			ex_pkg::alu_and:  result = opa & opb;
			ex_pkg::alu_or:   result = opa | opb;
			ex_pkg::alu_xor:  result = opa ^ opb;
			ex_pkg::alu_sll:  result = opa << shamt;
			ex_pkg::alu_srl:  result = opa >> shamt;
			ex_pkg::alu_sra:  result = sa >>> shamt;
			// multiply codes belong to the multiplier slots
			default:          result = '0;
		endcase
	end

	assign done = start;

	// carried along so the merge can rebuild the packet
	assign packet_out = packet_in;

endmodule

/* logic/ex_branch.sv */
// branch unit of the execute stage
// tests the branch condition on rs1 and rs2 and adds opa and opb for the target

`timescale 1ns/1ns

module ex_branch (
	input  logic [ex_pkg::xlen-1:0] opa,
	input  logic [ex_pkg::xlen-1:0] opb,
	input  logic [ex_pkg::xlen-1:0] rs1,
	input  logic [ex_pkg::xlen-1:0] rs2,
	input  logic [2:0]              funct3,
	input  logic                    start,
	input  ex_pkg::is_packet_t      packet_in,
	output logic [ex_pkg::xlen-1:0] target,
	output logic                    cond,
	output logic                    done,
	output ex_pkg::is_packet_t      packet_out
);

	logic [ex_pkg::xlen-1:0] sum;
	logic is_jalr;

	assign sum = opa + opb;
	assign is_jalr = (packet_in.inst.i.opcode == ex_pkg::opcode_jalr);

	// jalr target is always halfword aligned
	assign target = is_jalr ? {sum[ex_pkg::xlen-1:1], 1'b0} : sum;

	always_comb begin
		case (funct3)
			3'b000:  cond = (rs1 == rs2);
			3'b001:  cond = (rs1 != rs2);
			3'b100:  cond = ($signed(rs1) < $signed(rs2));
			3'b101:  cond = ($signed(rs1) >= $signed(rs2));
			3'b110:  cond = (rs1 < rs2);
			3'b111:  cond = (rs1 >= rs2);
			default: cond = 1'b0;
		endcase
	end

	assign done = start;
	assign packet_out = packet_in;

endmodule

/* logic/ex_multiplier.sv */
// iterative shift-add multiplier, one per multiply slot
// retires mul_bits_per_cycle multiplier bits per edge into a 64 bit sum
// done pulses one cycle with the product, busy covers the whole operation

`timescale 1ns/1ns

module ex_multiplier #(
	parameter int mul_bits_per_cycle = 8
) (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic [ex_pkg::xlen-1:0] opa,
	input  logic [ex_pkg::xlen-1:0] opb,
	input  ex_pkg::alu_func_e       func,
	input  ex_pkg::is_packet_t      packet_in,
	output logic [ex_pkg::xlen-1:0] product,
	output logic                    done,
	output logic                    busy,
	output ex_pkg::is_packet_t      packet_out
);

	localparam int steps = 64 / mul_bits_per_cycle;
	localparam int cnt_w = $clog2(steps + 1);

	logic a_signed;
	logic b_signed;
	logic [63:0] ext_a;
	logic [63:0] ext_b;
	logic [63:0] mcand;
	logic [63:0] mplier;
	logic [63:0] acc;
	logic [63:0] step_mcand;
	logic [63:0] step_mplier;
	logic [63:0] partial;
	logic [63:0] acc_next;
	logic [cnt_w-1:0] count;
	logic [cnt_w-1:0] count_next;
	ex_pkg::is_packet_t packet_q;

	// mulhu is unsigned on both sides, mulhsu only on b
	assign a_signed = (func != ex_pkg::alu_mulhu);
	assign b_signed = (func == ex_pkg::alu_mul) || (func == ex_pkg::alu_mulh);
	assign ext_a = {{32{a_signed & opa[31]}}, opa};
	assign ext_b = {{32{b_signed & opb[31]}}, opb};

	// first chunk retires on the start edge itself
	assign step_mcand = start ? ext_a : mcand;
	assign step_mplier = start ? ext_b : mplier;
	assign partial = step_mcand * 64'(step_mplier[mul_bits_per_cycle-1:0]);
	assign acc_next = (start ? 64'd0 : acc) + partial;
	assign count_next = start ? cnt_w'(1) : count + cnt_w'(1);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy <= 1'b1;
			done <= (count_next == cnt_w'(steps));
			count <= count_next;
		end else if (done) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (busy) begin
			done <= (count_next == cnt_w'(steps));
			count <= count_next;
		end
	end

	always_ff @(posedge clock) begin
		if (start || (busy && !done)) begin
			acc <= acc_next;
			mcand <= step_mcand << mul_bits_per_cycle;
			mplier <= step_mplier >> mul_bits_per_cycle;
		end
		if (start) begin
			packet_q <= packet_in;
		end
	end

	// mul keeps the low word, the mulh family the high word
	assign product = (packet_q.alu_func == ex_pkg::alu_mul) ? acc[31:0] : acc[63:32];
	assign packet_out = packet_q;

endmodule

/* logic/ex_result_fifo.sv */
// result queue between the execute units and the memory stage
// takes up to two packets per edge, slot_a first, and pops the head every edge
// head is shown combinationally, valid low while the queue is empty

`timescale 1ns/1ns

module ex_result_fifo #(
	parameter int fifo_depth = 8
) (
	input  logic               clock,
	input  logic               rst_n,
	input  ex_pkg::ex_packet_t slot_a,
	input  ex_pkg::ex_packet_t slot_b,
	output ex_pkg::ex_packet_t head,
	output logic               no_output
);

	localparam int ptr_w = $clog2(fifo_depth);
	localparam int cnt_w = $clog2(fifo_depth + 1);

	ex_pkg::ex_packet_t mem [fifo_depth];

	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] wr_ptr_b;
	logic [cnt_w-1:0] count;
	logic [1:0] n_wr;
	logic pop;

	assign n_wr = {1'b0, slot_a.valid} + {1'b0, slot_b.valid};
	assign pop = (count != '0);

	// slot_b lands behind slot_a when both are present
	assign wr_ptr_b = wr_ptr + ptr_w'(slot_a.valid);

	////////////////////
	// pointers and count
	////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			wr_ptr <= wr_ptr + ptr_w'(n_wr);
			if (pop) begin
				rd_ptr <= rd_ptr + ptr_w'(1);
			end
			count <= count + cnt_w'(n_wr) - cnt_w'(pop);
		end
	end

	////////////////////
	// storage
	////////////////////

	always_ff @(posedge clock) begin
		if (slot_a.valid) begin
			mem[wr_ptr] <= slot_a;
		end
		if (slot_b.valid) begin
			mem[wr_ptr_b] <= slot_b;
		end
	end

	assign no_output = (count == '0);
	assign head = no_output ? '0 : mem[rd_ptr];

endmodule

/* logic/ex_stage.sv */
// execute stage top level
// selects operands, dispatches to the alu, branch unit or a multiplier slot,
// merges finished results into the result queue and drives the btb update

`timescale 1ns/1ns

module ex_stage #(
	parameter int num_mults          = 2,
	parameter int mul_bits_per_cycle = 8,
	parameter int fifo_depth         = 8
) (
	input  logic                   clock,
	input  logic                   rst_n,
	input  ex_pkg::is_packet_t     issue_packet,
	output ex_pkg::ex_packet_t     ex_packet_out,
	output ex_pkg::ex2btb_packet_t btb_update,
	output logic                   mult_ready,
	output logic                   no_output
);

	logic [ex_pkg::xlen-1:0] opa;
	logic [ex_pkg::xlen-1:0] opb;

	logic alu_start;
	logic alu_done;
	logic [ex_pkg::xlen-1:0] alu_result;
	ex_pkg::is_packet_t alu_packet;

	logic br_start;
	logic br_done;
	logic br_cond;
	logic [ex_pkg::xlen-1:0] br_target;
	ex_pkg::is_packet_t br_packet;

	logic [num_mults-1:0] mul_start;
	logic [num_mults-1:0] mul_done;
	logic [num_mults-1:0] mul_busy;
	logic [num_mults-1:0] slot_free;
	logic [num_mults-1:0][ex_pkg::xlen-1:0] mul_product;
	ex_pkg::is_packet_t [num_mults-1:0] mul_packet;

	ex_pkg::ex_packet_t slot_a;
	ex_pkg::ex_packet_t slot_b;

	// rebuild an execute packet from what a unit carried
	function automatic ex_pkg::ex_packet_t make_ex(
		input ex_pkg::is_packet_t      p,
		input logic [ex_pkg::xlen-1:0] result,
		input logic                    taken
	);
		ex_pkg::ex_packet_t e;
		e.valid        = p.valid;
		e.pc           = p.pc;
		e.npc          = p.npc;
		e.alu_result   = result;
		e.take_branch  = taken;
		e.rs2_value    = p.rs2_value;
		e.dest_reg_idx = p.dest_reg_idx;
		e.rd_mem       = p.rd_mem;
		e.wr_mem       = p.wr_mem;
		e.mem_size     = p.inst.r.funct3;
		e.halt         = p.halt;
		return e;
	endfunction

	////////////////////
	// operand muxes
	////////////////////

	always_comb begin
		case (issue_packet.opa_select)
			ex_pkg::opa_is_rs1: opa = issue_packet.rs1_value;
			ex_pkg::opa_is_npc: opa = issue_packet.npc;
			ex_pkg::opa_is_pc:  opa = issue_packet.pc;
			default:            opa = '0;
		endcase
	end

	always_comb begin
		case (issue_packet.opb_select)
			ex_pkg::opb_is_rs2:   opb = issue_packet.rs2_value;
			ex_pkg::opb_is_i_imm: opb = ex_pkg::i_imm(issue_packet.inst);
			ex_pkg::opb_is_s_imm: opb = ex_pkg::s_imm(issue_packet.inst);
			ex_pkg::opb_is_b_imm: opb = ex_pkg::b_imm(issue_packet.inst);
			ex_pkg::opb_is_u_imm: opb = ex_pkg::u_imm(issue_packet.inst);
			ex_pkg::opb_is_j_imm: opb = ex_pkg::j_imm(issue_packet.inst);
			default:              opb = '0;
		endcase
	end

	////////////////////
	// dispatch
	////////////////////

	assign alu_start = (issue_packet.channel == ex_pkg::ch_alu);
	assign br_start = (issue_packet.channel == ex_pkg::ch_br);

	// a slot finishing this cycle can take a new multiply at the same edge
	assign slot_free = ~mul_busy | mul_done;
	assign mult_ready = |slot_free;

	// lowest free slot, isolated by the two's complement trick
	assign mul_start = (issue_packet.channel == ex_pkg::ch_mult) ?
		(slot_free & (~slot_free + num_mults'(1))) : '0;

	ex_alu u_alu (
		.opa        (opa),
		.opb        (opb),
		.func       (issue_packet.alu_func),
		.start      (alu_start),
		.packet_in  (issue_packet),
		.result     (alu_result),
		.done       (alu_done),
		.packet_out (alu_packet)
	);

	ex_branch u_branch (
		.opa        (opa),
		.opb        (opb),
		.rs1        (issue_packet.rs1_value),
		.rs2        (issue_packet.rs2_value),
		.funct3     (issue_packet.inst.b.funct3),
		.start      (br_start),
		.packet_in  (issue_packet),
		.target     (br_target),
		.cond       (br_cond),
		.done       (br_done),
		.packet_out (br_packet)
	);

	ex_multiplier #(
		.mul_bits_per_cycle (mul_bits_per_cycle)
	) u_mult [num_mults-1:0] (
		.clock      (clock),
		.rst_n      (rst_n),
		.start      (mul_start),
		.opa        (opa),
		.opb        (opb),
		.func       (issue_packet.alu_func),
		.packet_in  (issue_packet),
		.product    (mul_product),
		.done       (mul_done),
		.busy       (mul_busy),
		.packet_out (mul_packet)
	);

	////////////////////
	// result merge
	////////////////////

	// alu and branch unit never finish in the same cycle
	always_comb begin
		if (alu_done) begin
			slot_a = make_ex(alu_packet, alu_result, 1'b0);
		end else if (br_done) begin
			slot_a = make_ex(br_packet, br_target,
				br_packet.uncond_branch | (br_packet.cond_branch & br_cond));
		end else begin
			slot_a = '0;
		end
	end

	// scan downward so the lowest finishing slot wins
	always_comb begin
		slot_b = '0;
		for (int i = num_mults - 1; i >= 0; i--) begin
			if (mul_done[i]) begin
				slot_b = make_ex(mul_packet[i], mul_product[i], 1'b0);
			end
		end
	end

	ex_result_fifo #(
		.fifo_depth (fifo_depth)
	) u_fifo (
		.clock     (clock),
		.rst_n     (rst_n),
		.slot_a    (slot_a),
		.slot_b    (slot_b),
		.head      (ex_packet_out),
		.no_output (no_output)
	);

	// btb update follows the queue head
	assign btb_update.pc = ex_packet_out.pc;
	assign btb_update.target_pc = ex_packet_out.alu_result;
	assign btb_update.taken = ex_packet_out.take_branch;
	assign btb_update.valid = ex_packet_out.valid;

endmodule

/* bench/ex_stage_asserts.sv */
// concurrent checks on the result queue and the multiply issue rule
// bound into ex_result_fifo for the queue checks and into ex_stage for the issue check

`timescale 1ns/1ns

module ex_stage_asserts #(
	parameter int fifo_depth = 8,
	parameter bit issue_side = 1'b0
) (
	input logic                              clock,
	input logic                              rst_n,
	input logic [$clog2(fifo_depth + 1)-1:0] count,
	input logic [$clog2(fifo_depth)-1:0]     rd_ptr,
	input logic [$clog2(fifo_depth)-1:0]     wr_ptr,
	input logic                              no_output,
	input logic                              mult_issue,
	input logic                              mult_ready
);

	if (issue_side) begin : g_issue
		mult_only_when_ready: assert property (@(posedge clock) disable iff (!rst_n)
			mult_issue |-> mult_ready)
			else $error("multiply presented while mult_ready is low");
	end else begin : g_queue
		// with no back-pressure the issuer must keep the queue from overflowing
		count_in_range: assert property (@(posedge clock) disable iff (!rst_n)
			count <= fifo_depth)
			else $error("result queue holds %0d entries with depth %0d", count, fifo_depth);

		// pointers meet only when the queue is empty or exactly full
		empty_flag_matches: assert property (@(posedge clock) disable iff (!rst_n)
			(rd_ptr == wr_ptr) == (no_output || count == fifo_depth))
			else $error("no_output %b disagrees with read pointer %0d and write pointer %0d",
				no_output, rd_ptr, wr_ptr);
	end

endmodule

bind ex_result_fifo ex_stage_asserts #(
	.fifo_depth (fifo_depth),
	.issue_side (1'b0)
) u_queue_asserts (
	.clock      (clock),
	.rst_n      (rst_n),
	.count      (count),
	.rd_ptr     (rd_ptr),
	.wr_ptr     (wr_ptr),
	.no_output  (no_output),
	.mult_issue (1'b0),
	.mult_ready (1'b1)
);

bind ex_stage ex_stage_asserts #(
	.fifo_depth (fifo_depth),
	.issue_side (1'b1)
) u_issue_asserts (
	.clock      (clock),
	.rst_n      (rst_n),
	.count      ('0),
	.rd_ptr     ('0),
	.wr_ptr     ('0),
	.no_output  (1'b1),
	.mult_issue (issue_packet.channel == ex_pkg::ch_mult),
	.mult_ready (mult_ready)
);

/* bench/ex_stage_tb.sv */
// testbench for the execute stage
// reads bench/ex_tests.txt, drives issue packets on the falling edge and checks
// every execute packet and btb update; run from the project root

`timescale 1ns/1ns

module ex_stage_tb;

	localparam int num_mults          = 2;
	localparam int mul_bits_per_cycle = 8;
	localparam int fifo_depth         = 8;
	localparam int mul_latency        = 64 / mul_bits_per_cycle + 1;
	localparam int max_tests          = 64;

	typedef struct packed {
		logic [8*24-1:0]    name;
		logic               burst;
		ex_pkg::is_packet_t pkt;
		logic [31:0]        result;
		logic               take;
	} test_t;

	// one execute packet as it left the queue
	typedef struct packed {
		ex_pkg::ex_packet_t     pkt;
		ex_pkg::ex2btb_packet_t btb;
		logic [31:0]            edge_no;
	} seen_t;

	logic clock;
	logic rst_n;
	ex_pkg::is_packet_t issue_packet;
	ex_pkg::ex_packet_t ex_packet_out;
	ex_pkg::ex2btb_packet_t btb_update;
	logic mult_ready;
	logic no_output;

	test_t tests [max_tests];
	seen_t seen_q [$];
	int n_tests = 0;
	int pass_count = 0;
	int fail_count = 0;
	int seen_count = 0;
	int edge_count = 0;
	logic tests_loaded = 1'b0;
	logic load_failed = 1'b0;

	ex_stage #(
		.num_mults          (num_mults),
		.mul_bits_per_cycle (mul_bits_per_cycle),
		.fifo_depth         (fifo_depth)
	) u_ex_stage (
		.clock         (clock),
		.rst_n         (rst_n),
		.issue_packet  (issue_packet),
		.ex_packet_out (ex_packet_out),
		.btb_update    (btb_update),
		.mult_ready    (mult_ready),
		.no_output     (no_output)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		edge_count <= edge_count + 1;
	end

	// queue head is valid for one cycle, so grab it at every falling edge
	always @(negedge clock) begin : capture
		seen_t s;
		if (rst_n && !no_output) begin
			s.pkt = ex_packet_out;
			s.btb = btb_update;
			s.edge_no = edge_count;
			seen_q.push_back(s);
			seen_count++;
		end
	end

	////////////////////
	// tests file
	////////////////////

	task automatic load_tests();
		int fd;
		int n;
		int ch;
		int opa_s;
		int opb_s;
		int func;
		int cond;
		int uncond;
		int take;
		string line;
		logic [8*24-1:0] name_raw;
		logic [8*8-1:0] mode_raw;
		logic [31:0] pc;
		logic [31:0] inst;
		logic [31:0] rs1;
		logic [31:0] rs2;
		logic [31:0] result;
		ex_pkg::is_packet_t p;
		fd = $fopen("bench/ex_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open bench/ex_tests.txt");
			load_failed = 1'b1;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%s %s %d %d %d %d %d %d %h %h %h %h %h %d", name_raw, mode_raw,
				ch, opa_s, opb_s, func, cond, uncond, pc, inst, rs1, rs2, result, take);
			if (n != 14 || n_tests == max_tests ||
				(mode_raw != "single" && mode_raw != "burst")) begin
				$display("tests file line could not be read: %0s", line);
				load_failed = 1'b1;
				continue;
			end
			p = '0;
			p.valid = 1'b1;
			p.pc = pc;
			p.npc = pc + 32'd4;
			p.inst = ex_pkg::inst_t'(inst);
			p.rs1_value = rs1;
			p.rs2_value = rs2;
			p.opa_select = ex_pkg::opa_sel_e'(opa_s[1:0]);
			p.opb_select = ex_pkg::opb_sel_e'(opb_s[2:0]);
			p.alu_func = ex_pkg::alu_func_e'(func[3:0]);
			p.channel = ex_pkg::channel_e'(ch[1:0]);
			p.cond_branch = cond[0];
			p.uncond_branch = uncond[0];
			p.dest_reg_idx = inst[11:7];
			tests[n_tests].name = name_raw;
			tests[n_tests].burst = (mode_raw == "burst");
			tests[n_tests].pkt = p;
			tests[n_tests].result = result;
			tests[n_tests].take = take[0];
			n_tests++;
		end
		$fclose(fd);
	endtask

	////////////////////
	// checking
	////////////////////

	task automatic report_test(input logic [8*24-1:0] name, input logic ok);
		if (ok) begin
			pass_count++;
			$display("test %0s ok", name);
		end else begin
			fail_count++;
			$display("test %0s failed", name);
		end
	endtask

	task automatic check_result(input int idx, input seen_t s, input logic check_edge,
		input int exp_edge, output logic ok);
		ex_pkg::ex2btb_packet_t exp_btb;
		ok = 1'b1;
		exp_btb.pc = tests[idx].pkt.pc;
		exp_btb.target_pc = tests[idx].result;
		exp_btb.taken = tests[idx].take;
		exp_btb.valid = 1'b1;
		assert (s.pkt.alu_result == tests[idx].result) else begin
			$display("FAILED %0s alu_result expected %h actual %h", tests[idx].name,
				tests[idx].result, s.pkt.alu_result);
			ok = 1'b0;
		end
		assert (s.pkt.take_branch == tests[idx].take) else begin
			$display("FAILED %0s take_branch expected %b actual %b", tests[idx].name,
				tests[idx].take, s.pkt.take_branch);
			ok = 1'b0;
		end
		assert (s.pkt.pc == tests[idx].pkt.pc) else begin
			$display("FAILED %0s pc expected %h actual %h", tests[idx].name,
				tests[idx].pkt.pc, s.pkt.pc);
			ok = 1'b0;
		end
		assert (s.btb == exp_btb) else begin
			$display("FAILED %0s btb_update expected %h actual %h", tests[idx].name,
				exp_btb, s.btb);
			ok = 1'b0;
		end
		assert (!check_edge || s.edge_no == exp_edge) else begin
			$display("FAILED %0s result edge expected %0d actual %0d", tests[idx].name,
				exp_edge, s.edge_no);
			ok = 1'b0;
		end
	endtask

	task automatic check_reset_state();
		logic ok;
		ok = 1'b1;
		assert (no_output === 1'b1) else begin
			$display("FAILED reset_state no_output expected 1 actual %b", no_output);
			ok = 1'b0;
		end
		assert (ex_packet_out.valid === 1'b0 && btb_update.valid === 1'b0) else begin
			$display("FAILED reset_state valid expected 0 actual %b", ex_packet_out.valid);
			ok = 1'b0;
		end
		assert (mult_ready === 1'b1) else begin
			$display("FAILED reset_state mult_ready expected 1 actual %b", mult_ready);
			ok = 1'b0;
		end
		report_test("reset_state", ok);
	endtask

	////////////////////
	// stimulus
	////////////////////

	task automatic run_single(input int idx);
		int start_seen;
		int issue_edge;
		int exp_edge;
		logic ok;
		seen_t s;
		start_seen = seen_count;
		@(negedge clock);
		issue_packet = tests[idx].pkt;
		issue_edge = edge_count;
		@(negedge clock);
		issue_packet = '0;
		wait (seen_count > start_seen);
		s = seen_q.pop_front();
		if (tests[idx].pkt.channel == ex_pkg::ch_mult) begin
			exp_edge = issue_edge + mul_latency;
		end else begin
			exp_edge = issue_edge + 1;
		end
		check_result(idx, s, 1'b1, exp_edge, ok);
		report_test(tests[idx].name, ok);
	endtask

	// back to back multiplies, waiting out mult_ready where needed
	task automatic run_burst(input int first, input int count);
		int start_seen;
		logic saw_stall;
		logic ok;
		seen_t s;
		start_seen = seen_count;
		saw_stall = 1'b0;
		for (int k = 0; k < count; k++) begin
			@(negedge clock);
			while (!mult_ready) begin
				saw_stall = 1'b1;
				issue_packet = '0;
				@(negedge clock);
			end
			issue_packet = tests[first + k].pkt;
		end
		@(negedge clock);
		issue_packet = '0;
		wait (seen_count >= start_seen + count);
		for (int k = 0; k < count; k++) begin
			s = seen_q.pop_front();
			check_result(first + k, s, 1'b0, 0, ok);
			if (k == 0 && count > num_mults) begin
				assert (saw_stall) else begin
					$display("mult_ready never dropped during a burst of %0d multiplies", count);
					ok = 1'b0;
				end
			end
			report_test(tests[first + k].name, ok);
		end
	endtask

	initial begin
		int i;
		int j;
		clock = 1'b0;
		rst_n = 1'b0;
		issue_packet = '0;
		load_tests();
		tests_loaded = 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		check_reset_state();
		i = 0;
		while (i < n_tests) begin
			if (tests[i].burst) begin
				j = i;
				while (j < n_tests && tests[j].burst) begin
					j++;
				end
				run_burst(i, j - i);
				i = j;
			end else begin
				run_single(i);
				i++;
			end
		end
		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && !load_failed && n_tests > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// limit scales with the number of tests in the file
	initial begin
		wait (tests_loaded);
		repeat (n_tests * 40 + 100) @(posedge clock);
		$display("timeout after %0d cycles, the DUT stopped producing results",
			n_tests * 40 + 100);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* bench/ex_tests.txt */
# name mode channel opa_sel opb_sel alu_func cond uncond pc inst rs1 rs2 result take
# channel 1 alu 2 br 3 mult, selects and alu_func in package enum order, hex from pc on
add_rr          single 1 0 0 0  0 0 00000100 002081b3 00000005 00000007 0000000c 0
sub_rr          single 1 0 0 1  0 0 00000104 402081b3 00000003 00000005 fffffffe 0
sra_rr          single 1 0 0 9  0 0 00000108 4020d1b3 80000000 00000024 f8000000 0
sltu_rr         single 1 0 0 3  0 0 0000010c 0020b1b3 00000001 ffffffff 00000001 0
slt_rr          single 1 0 0 2  0 0 00000110 0020a1b3 ffffffff 00000001 00000001 0
addi_neg        single 1 0 1 0  0 0 00000114 ff008193 00000100 00000000 000000f0 0
lui             single 1 3 4 0  0 0 00000118 123451b7 00000000 00000000 12345000 0
auipc           single 1 2 4 0  0 0 00001000 00010197 00000000 00000000 00011000 0
beq_taken       single 2 2 3 0  1 0 00002000 00208863 00000005 00000005 00002010 1
beq_not         single 2 2 3 0  1 0 00002000 00208863 00000005 00000006 00002010 0
bne_taken       single 2 2 3 0  1 0 00002000 00209863 00000001 00000002 00002010 1
bne_not_back    single 2 2 3 0  1 0 00002000 fe209ce3 00000007 00000007 00001ff8 0
blt_taken_back  single 2 2 3 0  1 0 00002000 fe20cce3 fffffff0 00000001 00001ff8 1
blt_not         single 2 2 3 0  1 0 00002000 0020c863 00000001 fffffff0 00002010 0
bge_taken       single 2 2 3 0  1 0 00002000 0020d863 00000001 80000000 00002010 1
bge_not         single 2 2 3 0  1 0 00002000 0020d863 80000000 00000001 00002010 0
bltu_taken      single 2 2 3 0  1 0 00002000 0020e863 00000001 fffffff0 00002010 1
bltu_not        single 2 2 3 0  1 0 00002000 0020e863 fffffff0 00000001 00002010 0
bgeu_taken      single 2 2 3 0  1 0 00002000 0020f863 fffffff0 00000001 00002010 1
bgeu_not_back   single 2 2 3 0  1 0 00002000 fe20fce3 00000000 00000001 00001ff8 0
jal_fwd         single 2 2 5 0  0 1 00003000 100000ef 00000000 00000000 00003100 1
jalr_odd        single 2 0 1 0  0 1 00003004 005100e7 00004000 00000000 00004004 1
mul_neg         single 3 0 0 10 0 0 00000200 022081b3 ffffffff 00000007 fffffff9 0
mulh_min        single 3 0 0 11 0 0 00000204 022091b3 80000000 80000000 40000000 0
mulhsu_neg      single 3 0 0 12 0 0 00000208 0220a1b3 ffffffff ffffffff ffffffff 0
mulhu_max       single 3 0 0 13 0 0 0000020c 0220b1b3 ffffffff ffffffff fffffffe 0
burst_mul       burst  3 0 0 10 0 0 00005000 022081b3 00001234 00000010 00012340 0
burst_mulh      burst  3 0 0 11 0 0 00005004 022091b3 7fffffff 7fffffff 3fffffff 0
burst_mulhu     burst  3 0 0 13 0 0 00005008 0220b1b3 80000000 00000004 00000002 0

/* flist.f */
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_multiplier.sv
logic/ex_result_fifo.sv
logic/ex_stage.sv
bench/ex_stage_asserts.sv
bench/ex_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the execute stage testbench with verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module ex_stage_tb \
	-o ex_stage_sim \
	&& ./obj_dir/ex_stage_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }
